// File: src/udp_pkg.sv
// UDP transmit common definitions
package udp_pkg;

    // --------------------------------------------------
    // Data types
    // --------------------------------------------------
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] len_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // Frame sequencing, one state per frame section
    typedef enum logic [2:0] {
        st_idle,
        st_check_sum,       // Wait for header checksum
        st_preamble,
        st_eth_head,
        st_ip_head,         // IPv4 + UDP header words
        st_tx_data,
        st_crc
    } tx_state_e;

    // --------------------------------------------------
    // Ethernet framing
    // --------------------------------------------------
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam byte_t       PREAMBLE_BYTE = 8'h55;
    localparam byte_t       SFD_BYTE      = 8'hd5;
    localparam int          PREAMBLE_LEN  = 8;     // Includes the delimiter
    localparam int          ETH_HEAD_LEN  = 14;
    localparam int          HDR_WORDS     = 7;     // 20 IP + 8 UDP bytes

    // IPv4 and UDP fields
    localparam len_t        IP_HDR_BYTES  = 16'd20;
    localparam len_t        UDP_HDR_BYTES = 16'd8;
    localparam len_t        MIN_PAYLOAD   = 16'd18;  // 46 less both headers
    localparam byte_t       IP_VER_IHL    = 8'h45;
    localparam byte_t       IP_TTL        = 8'd64;
    localparam byte_t       IP_PROTO_UDP  = 8'd17;
    localparam logic [15:0] IP_FLAGS_DF   = 16'h4000;

    // CRC-32 in LSB-first form
    localparam word_t       CRC_POLY      = 32'hedb8_8320;
    localparam word_t       CRC_INIT      = 32'hffff_ffff;

endpackage

// File: src/crc32_d8.sv
// Ethernet CRC-32, one byte per cycle
module crc32_d8 import udp_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  crc_en,
    input  logic  crc_clr,
    input  byte_t crc_d,
    output word_t crc_next,
    output word_t crc
);

    word_t crc_q;

    // Eight LSB-first shift steps over one data byte
    function automatic word_t crc_byte(input word_t c_in, input byte_t d);
        word_t c;
        c = c_in ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_byte(crc_q, crc_d);
    assign crc      = crc_q;

    // --------------------------------------------------
    // Running remainder
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= CRC_INIT;
        end else if (crc_clr) begin
            crc_q <= CRC_INIT;          // Ready for the next frame
        end else if (crc_en) begin
            crc_q <= crc_next;
        end
    end

endmodule

// File: src/ip_header_gen.sv
// IPv4 and UDP header builder
module ip_header_gen import udp_pkg::*; #(
    parameter ip_addr_t    BOARD_IP = {8'd192, 8'd168, 8'd1, 8'd10},
    parameter ip_addr_t    DES_IP   = {8'd192, 8'd168, 8'd1, 8'd102},
    parameter logic [15:0] UDP_PORT = 16'd1234
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hdr_load,
    input  len_t       hdr_len,
    output logic       hdr_ready,
    input  logic [2:0] hdr_idx,
    output word_t      hdr_word
);

    localparam int SUM_WORDS = 5;       // Words covered by the IP checksum

    word_t      hdr_q [HDR_WORDS];
    logic [3:0] stage;                  // Checksum pipeline position
    logic [15:0] ident;
    word_t      acc;
    word_t      half_sum;
    len_t       ip_len;
    len_t       udp_len;

    assign ip_len  = hdr_len + IP_HDR_BYTES + UDP_HDR_BYTES;
    assign udp_len = hdr_len + UDP_HDR_BYTES;

    // Sum of the ten 16-bit halves, checksum field still zero
    always_comb begin
        half_sum = '0;
        for (int w = 0; w < SUM_WORDS; w++) begin
            half_sum = half_sum + hdr_q[w][31:16] + hdr_q[w][15:0];
        end
    end

    // --------------------------------------------------
    // Identification and checksum pipeline
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage <= '0;
            ident <= '0;
            acc   <= '0;
        end else begin
            stage <= {stage[2:0], hdr_load};
            if (hdr_load) begin
                ident <= ident + 16'd1;
            end
            if (stage[0]) begin
                acc <= half_sum;
            end else if (stage[1]) begin
                acc <= acc[31:16] + acc[15:0];      // First carry fold
            end
        end
    end

    // Header words
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            hdr_q[0] <= {IP_VER_IHL, 8'h00, ip_len};
            hdr_q[1] <= {ident + 16'd1, IP_FLAGS_DF};
            hdr_q[2] <= {IP_TTL, IP_PROTO_UDP, 16'h0000};
            hdr_q[3] <= BOARD_IP;
            hdr_q[4] <= DES_IP;
            hdr_q[5] <= {UDP_PORT, UDP_PORT};
            hdr_q[6] <= {udp_len, 16'h0000};    // No UDP checksum
        end
        if (stage[2]) begin
            // Second fold cannot carry again
            hdr_q[2][15:0] <= ~(acc[31:16] + acc[15:0]);
        end
    end

    assign hdr_ready = stage[3];

    always_comb begin
        if (hdr_idx < 3'(HDR_WORDS)) begin
            hdr_word = hdr_q[hdr_idx];
        end else begin
            hdr_word = '0;
        end
    end

endmodule

// File: src/udp_frame_ctrl.sv
// UDP frame sequencer for GMII
module udp_frame_ctrl import udp_pkg::*; #(
    parameter mac_addr_t BOARD_MAC = 48'h00_11_22_33_44_55,
    parameter mac_addr_t DES_MAC   = 48'hff_ff_ff_ff_ff_ff
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start_en,
    input  len_t       tx_byte_num,
    input  word_t      tx_data,
    output logic       tx_req,
    output logic       tx_done,
    output logic       gmii_tx_en,
    output byte_t      gmii_txd,
    output logic       hdr_load,
    output len_t       hdr_len,
    input  logic       hdr_ready,
    output logic [2:0] hdr_idx,
    input  word_t      hdr_word,
    output logic       crc_en,
    output logic       crc_clr,
    output byte_t      crc_d,
    input  word_t      crc_next,
    input  word_t      crc
);

    localparam logic [8*ETH_HEAD_LEN-1:0] ETH_HEAD = {DES_MAC, BOARD_MAC, ETH_TYPE_IPV4};

    localparam len_t PRE_LAST  = len_t'(PREAMBLE_LEN - 1);
    localparam len_t ETH_LAST  = len_t'(ETH_HEAD_LEN - 1);
    localparam len_t HDR_LAST  = len_t'(4 * HDR_WORDS - 1);
    localparam len_t REQ_FIRST = len_t'(4 * HDR_WORDS - 3);   // Two bytes before payload

    tx_state_e state;
    len_t      byte_cnt;        // Byte index within the current section
    len_t      byte_num_q;
    len_t      pad_len;         // Payload length after padding
    word_t     data_q;
    logic      fcs_last;
    logic [1:0] sel;
    logic [8*ETH_HEAD_LEN-1:0] eth_shift;
    byte_t     eth_byte;
    byte_t     hdr_byte;
    byte_t     data_byte;
    byte_t     fcs_byte;

    // MSB-first byte of a word
    function automatic byte_t pick_byte(input word_t w, input logic [1:0] s);
        return w[8*(3-s) +: 8];
    endfunction

    assign sel     = byte_cnt[1:0];
    assign hdr_idx = byte_cnt[4:2];
    assign hdr_len = byte_num_q;
    assign crc_d   = gmii_txd;      // CRC follows the line
    assign crc_clr = tx_done;

    // --------------------------------------------------
    // Byte sources
    // --------------------------------------------------
    assign eth_shift = ETH_HEAD << (8 * byte_cnt[3:0]);
    assign eth_byte  = eth_shift[8*ETH_HEAD_LEN-1 -: 8];
    assign hdr_byte  = pick_byte(hdr_word, sel);

    always_comb begin
        if (byte_cnt >= byte_num_q) begin
            data_byte = '0;                         // Zero padding
        end else if (sel == 2'd0) begin
            data_byte = tx_data[31:24];             // Fresh word straight from input
        end else begin
            data_byte = pick_byte(data_q, sel);
        end
    end

    // First FCS byte must include the last payload byte
    always_comb begin
        case (sel)
            2'd0:    fcs_byte = ~crc_next[7:0];
            2'd1:    fcs_byte = ~crc[15:8];
            2'd2:    fcs_byte = ~crc[23:16];
            default: fcs_byte = ~crc[31:24];
        endcase
    end

    // Hold the payload word for its remaining three bytes
    always_ff @(posedge clk) begin
        if (state == st_tx_data && sel == 2'd0) begin
            data_q <= tx_data;
        end
    end

    // --------------------------------------------------
    // Frame FSM with registered GMII outputs
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            byte_cnt   <= '0;
            byte_num_q <= '0;
            pad_len    <= '0;
            hdr_load   <= 1'b0;
            tx_req     <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= '0;
            crc_en     <= 1'b0;
            fcs_last   <= 1'b0;
        end else begin
            hdr_load   <= 1'b0;
            tx_req     <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= '0;
            crc_en     <= 1'b0;
            fcs_last   <= 1'b0;
            byte_cnt   <= byte_cnt + 16'd1;
            case (state)
                st_idle: begin
                    byte_cnt <= '0;
                    if (tx_start_en) begin
                        byte_num_q <= tx_byte_num;
                        pad_len    <= (tx_byte_num > MIN_PAYLOAD) ? tx_byte_num : MIN_PAYLOAD;
                        hdr_load   <= 1'b1;
                        state      <= st_check_sum;
                    end
                end
                st_check_sum: begin
                    byte_cnt <= '0;
                    if (hdr_ready) begin
                        state <= st_preamble;
                    end
                end
                st_preamble: begin
                    gmii_tx_en <= 1'b1;
                    gmii_txd   <= (byte_cnt == PRE_LAST) ? SFD_BYTE : PREAMBLE_BYTE;
                    if (byte_cnt == PRE_LAST) begin
                        byte_cnt <= '0;
                        state    <= st_eth_head;
                    end
                end
                st_eth_head: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= eth_byte;
                    if (byte_cnt == ETH_LAST) begin
                        byte_cnt <= '0;
                        state    <= st_ip_head;
                    end
                end
                st_ip_head: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= hdr_byte;
                    if (byte_cnt == REQ_FIRST) begin
                        tx_req <= 1'b1;             // First payload word
                    end
                    if (byte_cnt == HDR_LAST) begin
                        byte_cnt <= '0;
                        state    <= st_tx_data;
                    end
                end
                st_tx_data: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= data_byte;
                    // Next word due three bytes on, if any remain
                    if (sel == 2'd1 && byte_cnt + 17'd3 < byte_num_q) begin
                        tx_req <= 1'b1;
                    end
                    if (byte_cnt == pad_len - 16'd1) begin
                        byte_cnt <= '0;
                        state    <= st_crc;
                    end
                end
                st_crc: begin
                    gmii_tx_en <= 1'b1;
                    gmii_txd   <= fcs_byte;
                    if (sel == 2'd3) begin
                        fcs_last <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Done once the last FCS byte has left the port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_done <= 1'b0;
        end else begin
            tx_done <= fcs_last;
        end
    end

endmodule

// File: src/udp_tx_top.sv
// UDP/IPv4 GMII transmitter
module udp_tx_top import udp_pkg::*; #(
    parameter mac_addr_t   BOARD_MAC = 48'h00_11_22_33_44_55,
    parameter mac_addr_t   DES_MAC   = 48'h84_a9_3e_19_30_8a,
    parameter ip_addr_t    BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd10},
    parameter ip_addr_t    DES_IP    = {8'd192, 8'd168, 8'd1, 8'd102},
    parameter logic [15:0] UDP_PORT  = 16'd1234     // Source and destination
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tx_start_en,
    input  len_t  tx_byte_num,
    input  word_t tx_data,
    output logic  tx_req,
    output logic  tx_done,
    output logic  gmii_tx_en,
    output byte_t gmii_txd
);

    // Header generator link
    logic       hdr_load;
    len_t       hdr_len;
    logic       hdr_ready;
    logic [2:0] hdr_idx;
    word_t      hdr_word;

    // CRC link
    logic  crc_en;
    logic  crc_clr;
    byte_t crc_d;
    word_t crc_next;
    word_t crc;

    udp_frame_ctrl #(
        .BOARD_MAC (BOARD_MAC),
        .DES_MAC   (DES_MAC)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .tx_data     (tx_data),
        .tx_req      (tx_req),
        .tx_done     (tx_done),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd),
        .hdr_load    (hdr_load),
        .hdr_len     (hdr_len),
        .hdr_ready   (hdr_ready),
        .hdr_idx     (hdr_idx),
        .hdr_word    (hdr_word),
        .crc_en      (crc_en),
        .crc_clr     (crc_clr),
        .crc_d       (crc_d),
        .crc_next    (crc_next),
        .crc         (crc)
    );

    ip_header_gen #(
        .BOARD_IP (BOARD_IP),
        .DES_IP   (DES_IP),
        .UDP_PORT (UDP_PORT)
    ) u_hdr (
        .clk       (clk),
        .rst_n     (rst_n),
        .hdr_load  (hdr_load),
        .hdr_len   (hdr_len),
        .hdr_ready (hdr_ready),
        .hdr_idx   (hdr_idx),
        .hdr_word  (hdr_word)
    );

    crc32_d8 u_crc (
        .clk      (clk),
        .rst_n    (rst_n),
        .crc_en   (crc_en),
        .crc_clr  (crc_clr),
        .crc_d    (crc_d),
        .crc_next (crc_next),
        .crc      (crc)
    );

endmodule

// File: test/udp_frame_model.svh
// Expected UDP frame builder
`ifndef UDP_FRAME_MODEL_SVH
`define UDP_FRAME_MODEL_SVH

// One's complement sum of the IPv4 header with a zero checksum field
function automatic logic [15:0] ip_checksum(input len_t n, input logic [15:0] ident);
    logic [31:0] sum;
    sum = 32'h4500 + 32'(n + 16'd28) + 32'(ident) + 32'h4000 + 32'h4011;
    sum = sum + 32'(BOARD_IP[31:16]) + 32'(BOARD_IP[15:0]);
    sum = sum + 32'(DES_IP[31:16]) + 32'(DES_IP[15:0]);
    while (sum[31:16] != 16'h0000) begin
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};   // End-around carry
    end
    return ~sum[15:0];
endfunction

// Bit-serial Ethernet CRC-32 over the frame body
function automatic word_t body_fcs();
    word_t c;
    logic  fb;
    c = 32'hffff_ffff;
    foreach (body_q[i]) begin
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ body_q[i][b];       // Bits enter LSB first
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hedb8_8320;
            end
        end
    end
    return ~c;
endfunction

// Append the low count bytes of value, most significant first
task automatic push_bytes(input logic [63:0] value, input int count);
    for (int k = count - 1; k >= 0; k--) begin
        body_q.push_back(value[8*k +: 8]);
    end
endtask

// --------------------------------------------------
// Whole frame as it should appear on GMII
// --------------------------------------------------
task automatic build_expected(input len_t n, input logic [15:0] ident);
    word_t       fcs;
    logic [15:0] csum;
    csum = ip_checksum(n, ident);
    body_q.delete();
    expected_q.delete();
    push_bytes(64'(DES_MAC), 6);
    push_bytes(64'(BOARD_MAC), 6);
    push_bytes(64'h0800, 2);                 // IPv4 type
    push_bytes(64'h4500, 2);
    push_bytes(64'(n + 16'd28), 2);          // Total length
    push_bytes(64'(ident), 2);
    push_bytes(64'h4000, 2);                 // Don't fragment
    push_bytes(64'h4011, 2);                 // TTL 64, UDP
    push_bytes(64'(csum), 2);
    push_bytes(64'(BOARD_IP), 4);
    push_bytes(64'(DES_IP), 4);
    push_bytes(64'({UDP_PORT, UDP_PORT}), 4);
    push_bytes(64'(n + 16'd8), 2);           // UDP length
    push_bytes(64'h0000, 2);
    foreach (payload_q[i]) begin
        body_q.push_back(payload_q[i]);
    end
    while (body_q.size() < 14 + 28 + 18) begin
        body_q.push_back(8'h00);             // Minimum frame padding
    end
    fcs = body_fcs();
    for (int i = 0; i < 7; i++) begin
        expected_q.push_back(8'h55);
    end
    expected_q.push_back(8'hd5);
    foreach (body_q[i]) begin
        expected_q.push_back(body_q[i]);
    end
    for (int k = 0; k < 4; k++) begin
        expected_q.push_back(fcs[8*k +: 8]);
    end
endtask

`endif

// File: test/tb_udp_tx.sv
// UDP transmitter testbench
module tb_udp_tx import udp_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam mac_addr_t   BOARD_MAC   = 48'h02_1a_2b_3c_4d_5e;
    localparam mac_addr_t   DES_MAC     = 48'h84_a9_3e_19_30_8a;
    localparam ip_addr_t    BOARD_IP    = {8'd10, 8'd0, 8'd0, 8'd2};
    localparam ip_addr_t    DES_IP      = {8'd10, 8'd0, 8'd0, 8'd9};
    localparam logic [15:0] UDP_PORT    = 16'd5001;
    localparam int          SEED        = 27311;
    localparam int          NUM_B2B     = 4;
    localparam int          PAYLOAD_OFS = 50;     // Preamble, Ethernet, IP and UDP headers

    logic  clk;
    logic  rst_n;
    logic  tx_start_en;
    len_t  tx_byte_num;
    word_t tx_data;
    logic  tx_req;
    logic  tx_done;
    logic  gmii_tx_en;
    byte_t gmii_txd;

    byte_t       payload_q [$];
    byte_t       body_q [$];
    byte_t       expected_q [$];
    byte_t       captured_q [$];
    int          word_idx = 0;
    int          req_count = 0;
    int          done_count = 0;
    int          frame_count = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          seed_ret;
    logic        en_prev = 1'b0;
    logic [15:0] next_ident;
    len_t        b2b_len [NUM_B2B];

    udp_tx_top #(
        .BOARD_MAC (BOARD_MAC),
        .DES_MAC   (DES_MAC),
        .BOARD_IP  (BOARD_IP),
        .DES_IP    (DES_IP),
        .UDP_PORT  (UDP_PORT)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .tx_data     (tx_data),
        .tx_req      (tx_req),
        .tx_done     (tx_done),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd)
    );

    `include "udp_frame_model.svh"

    always #50 clk = ~clk;

    // --------------------------------------------------
    // Error handling and compare tasks
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_pulse(input string what, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("%s pulsed %0d times during the frame where %0d were expected",
                                what, got, exp));
        end
    endtask

    task automatic check_quiet();
        if (gmii_tx_en !== 1'b0 || tx_req !== 1'b0 || tx_done !== 1'b0) begin
            abort_run("An output was active while the transmitter should be idle");
        end
        check_byte("gmii_txd", gmii_txd, 8'h00);
    endtask

    // Payload word k holds bytes 4k to 4k+3 with filler past the end
    function automatic word_t word_at(input int idx);
        word_t w;
        int    pos;
        w = '0;
        for (int b = 0; b < 4; b++) begin
            pos = 4 * idx + b;
            w   = {w[23:0], (pos < payload_q.size()) ? payload_q[pos] : 8'hee};
        end
        return w;
    endfunction

    function automatic int frame_budget(input len_t n);
        return int'((n > 16'd18) ? n : 16'd18) + 70;
    endfunction

    task automatic random_payload(input len_t n);
        payload_q.delete();
        for (int i = 0; i < int'(n); i++) begin
            payload_q.push_back(byte_t'($urandom));
        end
    endtask

    // --------------------------------------------------
    // Payload responder, capture monitor and timeout
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst_n === 1'b1 && tx_req === 1'b1) begin
            if (4 * word_idx >= payload_q.size()) begin
                abort_run("tx_req asked for a word beyond the end of the payload");
            end else begin
                tx_data   <= word_at(word_idx);
                word_idx  = word_idx + 1;
                req_count = req_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (gmii_tx_en === 1'b1) begin
            captured_q.push_back(gmii_txd);
        end
        if (gmii_tx_en === 1'b1 && en_prev !== 1'b1) begin
            frame_count = frame_count + 1;
        end
        if (tx_done === 1'b1) begin
            done_count = done_count + 1;
            if (!(en_prev === 1'b1 && gmii_tx_en === 1'b0)) begin
                abort_run("tx_done pulsed outside the cycle after gmii_tx_en fell");
            end
        end else if (en_prev === 1'b1 && gmii_tx_en === 1'b0) begin
            abort_run("tx_done did not follow the end of a frame");
        end
        en_prev = gmii_tx_en;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            abort_run("Timeout: the tests did not finish within the cycle budget");
        end
    end

    // --------------------------------------------------
    // Frame driver with generic checks
    // --------------------------------------------------
    task automatic run_frame(input len_t n, input bit poke_mid);
        word_idx    = 0;
        req_count   = 0;
        done_count  = 0;
        frame_count = 0;
        captured_q.delete();
        build_expected(n, next_ident);
        @(posedge clk);
        tx_start_en <= 1'b1;
        tx_byte_num <= n;
        @(posedge clk);
        tx_start_en <= 1'b0;
        if (poke_mid) begin
            while (gmii_tx_en !== 1'b1) begin
                @(posedge clk);
            end
            repeat (20) @(posedge clk);
            tx_start_en <= 1'b1;            // Must be ignored mid-frame
            tx_byte_num <= 16'd7;
            @(posedge clk);
            tx_start_en <= 1'b0;
        end
        @(posedge clk);
        while (tx_done !== 1'b1) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);          // Quiet tail
        check_len("frame length", len_t'(captured_q.size()), len_t'(expected_q.size()));
        foreach (expected_q[i]) begin
            check_byte($sformatf("gmii_txd byte %0d", i), captured_q[i], expected_q[i]);
        end
        check_pulse("tx_req", req_count, (int'(n) + 3) / 4);
        check_pulse("tx_done", done_count, 1);
        check_pulse("gmii_tx_en frame start", frame_count, 1);
        next_ident = next_ident + 16'd1;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_quiet();
        @(posedge clk);                     // First edge applies the reset
        @(posedge clk);
        check_quiet();
        rst_n <= 1'b1;
        repeat (6) begin
            @(posedge clk);
            check_quiet();
        end
    endtask

    task automatic test_full_frame();
        random_payload(16'd32);
        run_frame(16'd32, 1'b0);
    endtask

    task automatic test_short_payload();
        random_payload(16'd5);
        run_frame(16'd5, 1'b0);
        check_len("short frame length", len_t'(captured_q.size()), 16'd72);
        for (int i = 5; i < 18; i++) begin
            check_byte($sformatf("pad byte %0d", i), captured_q[PAYLOAD_OFS + i], 8'h00);
        end
    endtask

    task automatic test_odd_length();
        random_payload(16'd23);
        run_frame(16'd23, 1'b0);
        check_len("ip total length", {captured_q[24], captured_q[25]}, 16'd51);
        check_len("udp length", {captured_q[PAYLOAD_OFS - 4], captured_q[PAYLOAD_OFS - 3]},
                  16'd31);
    endtask

    task automatic test_back_to_back();
        logic [15:0] ident;
        for (int i = 0; i < NUM_B2B; i++) begin
            ident = next_ident;
            random_payload(b2b_len[i]);
            run_frame(b2b_len[i], i == 1);
            check_len("identification", {captured_q[26], captured_q[27]}, ident);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        tx_start_en = 1'b0;
        tx_byte_num = '0;
        tx_data     = '0;
        seed_ret    = $urandom(SEED);
        next_ident  = 16'd1;
        cycle_limit = frame_budget(16'd32) + frame_budget(16'd5) + frame_budget(16'd23);
        for (int i = 0; i < NUM_B2B; i++) begin
            b2b_len[i]  = len_t'($urandom_range(64, 1));
            cycle_limit = cycle_limit + frame_budget(b2b_len[i]);
        end
        cycle_limit = 2 * cycle_limit;
        test_reset_quiet();
        test_full_frame();
        test_short_payload();
        test_odd_length();
        test_back_to_back();
        repeat (5) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: tb.f
+incdir+test
src/udp_pkg.sv
src/crc32_d8.sv
src/ip_header_gen.sv
src/udp_frame_ctrl.sv
src/udp_tx_top.sv
test/tb_udp_tx.sv

// File: Makefile
# Verilator flow for the UDP transmitter

VERILATOR ?= verilator
TOP       ?= tb_udp_tx
RTL_TOP   ?= udp_tx_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal
LINTFLAGS ?= -Wall
PASS_MSG  ?= RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides pass or fail
sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
